/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f all.f --top-module rename_tb -o Vrename_tb

run: compile
	@out=$$(./obj_dir/Vrename_tb); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+common
common/rename_pkg.sv
rat/rat.sv
rob/rob_ptr_counter.sv
rob/rob_store.sv
verilog/retire_fsm.sv
verilog/rename_top.sv
sim/tb_clock_gen.sv
sim/rename_checker.sv
sim/rename_tb.sv

/* common/rename_macros.svh */
// sizing for the rename subsystem; the ROB depth must be a power of two and match the id width
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// data width of one integer register
`define RENAME_XLEN 32

// reorder buffer entries and log2 of that count
`define RENAME_ROB_DEPTH 8
`define RENAME_ROB_ID_W 3

`endif

/* common/rename_pkg.sv */
// shared types for rename and retire; widths come from rename_macros.svh, 32 arch registers fixed
`include "rename_macros.svh"

package rename_pkg;

  // one register value
  typedef logic [`RENAME_XLEN-1:0] word_t;

  // architectural register index, x0 reads zero
  typedef logic [4:0] arch_reg_t;

  // reorder buffer entry id
  typedef logic [`RENAME_ROB_ID_W-1:0] rob_id_t;

  // retire machine states
  typedef enum logic {
    ret_run,
    ret_flush
  } retire_state_t;

endpackage

/* rat/rat.sv */
// register alias table; reads are combinational and forward a same-cycle writeback, x0 is hardwired
`timescale 1ns/1ns
`include "rename_macros.svh"

module rat (
  input  logic                clk,
  input  logic                reset,
  input  rename_pkg::arch_reg_t rename_rs1,
  input  rename_pkg::arch_reg_t rename_rs2,
  input  logic                rename_alloc,
  input  rename_pkg::arch_reg_t rename_rd,
  input  rename_pkg::rob_id_t rename_robid,
  input  logic                wb_valid,
  input  logic                wb_error,
  input  rename_pkg::rob_id_t wb_robid,
  input  logic                wb_has_rd,
  input  rename_pkg::arch_reg_t wb_rd,
  input  rename_pkg::word_t   wb_result,
  input  logic                rob_flush,
  input  logic                commit,
  input  logic                head_has_rd,
  input  rename_pkg::arch_reg_t head_rd,
  input  rename_pkg::word_t   head_result,
  output logic                rs1_valid,
  output rename_pkg::word_t   rs1_tagval,
  output logic                rs2_valid,
  output rename_pkg::word_t   rs2_tagval
);

  logic [31:0]         valid_flag;
  logic [31:0]         committed_flag;
  rename_pkg::rob_id_t tag_mem [32];
  rename_pkg::word_t   spec_mem [32];
  rename_pkg::word_t   comm_mem [32];

  logic wb_write;
  logic fwd_rs1;
  logic fwd_rs2;
  logic rd_write;
  logic comm_write;

  // writeback only lands while it is still the newest producer of its register
  assign wb_write = wb_valid && !wb_error && wb_has_rd && (wb_rd != '0) &&
                    (wb_robid == tag_mem[wb_rd]);
  assign fwd_rs1 = wb_write && (wb_rd == rename_rs1);
  assign fwd_rs2 = wb_write && (wb_rd == rename_rs2);

  // renames of x0 never take a tag
  assign rd_write = rename_alloc && (rename_rd != '0);
  assign comm_write = commit && head_has_rd && (head_rd != '0);

  // flags; a rename clear beats a writeback set on the same register
  always_ff @(posedge clk) begin
    if (reset || rob_flush) begin
      valid_flag <= '1;
      committed_flag <= '1;
    end else begin
      if (wb_write) begin
        valid_flag[wb_rd] <= 1'b1;
      end
      if (rd_write) begin
        valid_flag[rename_rd] <= 1'b0;
        committed_flag[rename_rd] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_write) begin
      tag_mem[rename_rd] <= rename_robid;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_write) begin
      spec_mem[wb_rd] <= wb_result;
    end
  end

  // architectural state, zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        comm_mem[i] <= '0;
      end
    end else if (comm_write) begin
      comm_mem[head_rd] <= head_result;
    end
  end

  // forward, x0, committed, speculative, then the pending tag
  function automatic rename_pkg::word_t read_src(input rename_pkg::arch_reg_t rs,
                                                 input logic fwd);
    rename_pkg::word_t val;
    if (fwd) begin
      val = wb_result;
    end else if (rs == '0) begin
      val = '0;
    end else if (committed_flag[rs]) begin
      val = comm_mem[rs];
    end else if (valid_flag[rs]) begin
      val = spec_mem[rs];
    end else begin
      val = {{(`RENAME_XLEN-`RENAME_ROB_ID_W){1'b0}}, tag_mem[rs]};
    end
    return val;
  endfunction

  always_comb begin
    rs1_valid = valid_flag[rename_rs1] || fwd_rs1;
    rs2_valid = valid_flag[rename_rs2] || fwd_rs2;
    rs1_tagval = read_src(rename_rs1, fwd_rs1);
    rs2_tagval = read_src(rename_rs2, fwd_rs2);
  end

endmodule

/* rob/rob_ptr_counter.sv */
// ROB head/tail pointers; depth must be a power of two so the pointers wrap on their own
`timescale 1ns/1ns
`include "rename_macros.svh"

module rob_ptr_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                alloc,
  input  logic                commit,
  input  logic                rob_flush,
  output rename_pkg::rob_id_t head,
  output rename_pkg::rob_id_t tail,
  output logic                full,
  output logic                empty
);

  localparam logic [`RENAME_ROB_ID_W:0] depth_cnt = `RENAME_ROB_DEPTH;

  // one extra bit so full and empty differ
  logic [`RENAME_ROB_ID_W:0] count;

  always_ff @(posedge clk) begin
    if (reset || rob_flush) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (commit) begin
        head <= head + 1'b1;
      end
      // alloc and commit together leave the count alone
      if (alloc && !commit) begin
        count <= count + 1'b1;
      end else if (commit && !alloc) begin
        count <= count - 1'b1;
      end
    end
  end

  assign full = (count == depth_cnt);
  assign empty = (count == '0);

endmodule

/* rob/rob_store.sv */
// ROB entry storage; writebacks are trusted to target allocated entries only
`timescale 1ns/1ns
`include "rename_macros.svh"

module rob_store (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  alloc,
  input  rename_pkg::rob_id_t   tail,
  input  logic                  rename_has_rd,
  input  rename_pkg::arch_reg_t rename_rd,
  input  logic                  wb_valid,
  input  rename_pkg::rob_id_t   wb_robid,
  input  rename_pkg::word_t     wb_result,
  input  logic                  wb_error,
  input  rename_pkg::rob_id_t   head,
  input  logic                  rob_flush,
  output logic                  head_done,
  output logic                  head_error,
  output logic                  head_has_rd,
  output rename_pkg::arch_reg_t head_rd,
  output rename_pkg::word_t     head_result,
  output logic                  wb_has_rd,
  output rename_pkg::arch_reg_t wb_rd
);

  logic [`RENAME_ROB_DEPTH-1:0] done_flag;
  logic [`RENAME_ROB_DEPTH-1:0] error_flag;
  logic [`RENAME_ROB_DEPTH-1:0] has_rd_flag;
  rename_pkg::arch_reg_t        rd_mem [`RENAME_ROB_DEPTH];
  rename_pkg::word_t            result_mem [`RENAME_ROB_DEPTH];

  // done marks a finished entry
  always_ff @(posedge clk) begin
    if (reset || rob_flush) begin
      done_flag <= '0;
    end else begin
      if (wb_valid) begin
        done_flag[wb_robid] <= 1'b1;
      end
      if (alloc) begin
        done_flag[tail] <= 1'b0;
      end
    end
  end

  // destination recorded at allocation
  always_ff @(posedge clk) begin
    if (alloc) begin
      has_rd_flag[tail] <= rename_has_rd;
      rd_mem[tail] <= rename_rd;
    end
  end

  // error is only meaningful once done is set
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      error_flag[wb_robid] <= wb_error;
      result_mem[wb_robid] <= wb_result;
    end
  end

  assign head_done = done_flag[head];
  assign head_error = error_flag[head];
  assign head_has_rd = has_rd_flag[head];
  assign head_rd = rd_mem[head];
  assign head_result = result_mem[head];

  // destination lookup for the alias table
  assign wb_has_rd = has_rd_flag[wb_robid];
  assign wb_rd = rd_mem[wb_robid];

endmodule

/* sim/rename_checker.sv */
// compares DUT ports with expected values at each rising edge; expected values must be set at the falling edge
`timescale 1ns/1ns

module rename_checker (
  input  logic                  clk,
  input  logic                  chk_en,
  input  logic                  test_end,
  input  int                    test_num,
  input  logic                  report,
  input  logic                  exp_ready,
  input  rename_pkg::rob_id_t   exp_robid,
  input  logic                  exp_rs1_valid,
  input  rename_pkg::word_t     exp_rs1_val,
  input  logic                  exp_rs2_valid,
  input  rename_pkg::word_t     exp_rs2_val,
  input  logic                  exp_retire,
  input  rename_pkg::arch_reg_t exp_ret_rd,
  input  logic                  exp_ret_has,
  input  rename_pkg::word_t     exp_ret_res,
  input  logic                  exp_flush,
  input  logic                  rename_ready,
  input  rename_pkg::rob_id_t   rename_robid,
  input  logic                  rs1_valid,
  input  rename_pkg::word_t     rs1_tagval,
  input  logic                  rs2_valid,
  input  rename_pkg::word_t     rs2_tagval,
  input  logic                  retire_valid,
  input  rename_pkg::arch_reg_t retire_rd,
  input  logic                  retire_has_rd,
  input  rename_pkg::word_t     retire_result,
  input  logic                  flush,
  output int                    err_total
);

  int errs = 0;
  int test_errs = 0;
  int checks = 0;

  assign err_total = errs;

  task automatic compare_field(input string name, input logic [31:0] e, input logic [31:0] g);
    checks++;
    if (e !== g) begin
      $display("[ERROR] t=%0t %s exp=%h got=%h", $time, name, e, g);
      errs++;
      test_errs++;
    end
  endtask

  always @(posedge clk) begin
    if (chk_en) begin
      compare_field("rename_ready", 32'(exp_ready), 32'(rename_ready));
      compare_field("rename_robid", 32'(exp_robid), 32'(rename_robid));
      compare_field("rs1_valid", 32'(exp_rs1_valid), 32'(rs1_valid));
      compare_field("rs1_tagval", exp_rs1_val, rs1_tagval);
      compare_field("rs2_valid", 32'(exp_rs2_valid), 32'(rs2_valid));
      compare_field("rs2_tagval", exp_rs2_val, rs2_tagval);
      compare_field("flush", 32'(exp_flush), 32'(flush));
      compare_field("retire_valid", 32'(exp_retire), 32'(retire_valid));
      // destination fields only mean something on a retire
      if (exp_retire && retire_valid) begin
        compare_field("retire_rd", 32'(exp_ret_rd), 32'(retire_rd));
        compare_field("retire_has_rd", 32'(exp_ret_has), 32'(retire_has_rd));
        compare_field("retire_result", exp_ret_res, retire_result);
      end
    end
    if (test_end) begin
      $display("test %0d finished with %0d errors", test_num, test_errs);
      test_errs = 0;
    end
    if (report) begin
      $display("summary: %0d checks, %0d errors", checks, errs);
    end
  end

endmodule

/* sim/rename_tb.sv */
// testbench for rename_top; inputs change on the falling edge and the model runs one cycle behind
`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_tb;

  localparam int test_cycles = 16 + 220;
  localparam int margin_cycles = 100;

  logic clk;
  logic reset;
  logic rename_valid = 1'b0;
  logic rename_has_rd = 1'b0;
  logic wb_valid = 1'b0;
  logic wb_error = 1'b0;
  rename_pkg::arch_reg_t rename_rs1 = '0;
  rename_pkg::arch_reg_t rename_rs2 = '0;
  rename_pkg::arch_reg_t rename_rd = '0;
  rename_pkg::rob_id_t wb_robid = '0;
  rename_pkg::word_t wb_result = '0;
  logic rename_ready, rs1_valid, rs2_valid, retire_valid, retire_has_rd, flush;
  rename_pkg::rob_id_t rename_robid;
  rename_pkg::word_t rs1_tagval, rs2_tagval, retire_result;
  rename_pkg::arch_reg_t retire_rd;

  // expected port values and checker control
  logic chk_en = 1'b0, test_end = 1'b0, end_req = 1'b0, report = 1'b0;
  int test_num = 0;
  int err_total;
  logic exp_ready = 1'b1, exp_rs1_valid = 1'b1, exp_rs2_valid = 1'b1;
  logic exp_retire = 1'b0, exp_ret_has = 1'b0, exp_flush = 1'b0, go_flush = 1'b0;
  rename_pkg::rob_id_t exp_robid = '0;
  rename_pkg::word_t exp_rs1_val = '0, exp_rs2_val = '0, exp_ret_res = '0;
  rename_pkg::arch_reg_t exp_ret_rd = '0;

  // reference model state for registers and ROB entries
  rename_pkg::word_t arch [32];
  rename_pkg::word_t spec [32];
  logic pend [32];
  logic renamed [32];
  rename_pkg::rob_id_t tagr [32];
  logic ent_done [`RENAME_ROB_DEPTH];
  logic ent_err [`RENAME_ROB_DEPTH];
  logic ent_has [`RENAME_ROB_DEPTH];
  rename_pkg::arch_reg_t ent_rd [`RENAME_ROB_DEPTH];
  rename_pkg::word_t ent_res [`RENAME_ROB_DEPTH];
  rename_pkg::rob_id_t head_m = '0, tail_m = '0;
  int count_m = 0;
  logic flushing = 1'b0;
  logic accepted;
  rename_pkg::rob_id_t outstanding [$];
  int seed = 32'h9fc7;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  rename_top u_dut (
    .clk(clk), .reset(reset), .rename_valid(rename_valid), .rename_ready(rename_ready),
    .rename_rs1(rename_rs1), .rename_rs2(rename_rs2), .rename_has_rd(rename_has_rd),
    .rename_rd(rename_rd), .rename_robid(rename_robid),
    .rs1_valid(rs1_valid), .rs1_tagval(rs1_tagval), .rs2_valid(rs2_valid), .rs2_tagval(rs2_tagval),
    .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_result(wb_result), .wb_error(wb_error),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_has_rd(retire_has_rd),
    .retire_result(retire_result), .flush(flush)
  );

  rename_checker u_chk (
    .clk(clk), .chk_en(chk_en), .test_end(test_end), .test_num(test_num), .report(report),
    .exp_ready(exp_ready), .exp_robid(exp_robid),
    .exp_rs1_valid(exp_rs1_valid), .exp_rs1_val(exp_rs1_val),
    .exp_rs2_valid(exp_rs2_valid), .exp_rs2_val(exp_rs2_val),
    .exp_retire(exp_retire), .exp_ret_rd(exp_ret_rd), .exp_ret_has(exp_ret_has),
    .exp_ret_res(exp_ret_res), .exp_flush(exp_flush),
    .rename_ready(rename_ready), .rename_robid(rename_robid),
    .rs1_valid(rs1_valid), .rs1_tagval(rs1_tagval), .rs2_valid(rs2_valid), .rs2_tagval(rs2_tagval),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_has_rd(retire_has_rd),
    .retire_result(retire_result), .flush(flush), .err_total(err_total)
  );

  // expected source read in the order forward, x0, committed, speculative, pending tag
  function automatic rename_pkg::word_t src_expect(input rename_pkg::arch_reg_t rs,
      input logic fwd, input rename_pkg::arch_reg_t frd, input rename_pkg::word_t fres,
      output logic v);
    rename_pkg::word_t val;
    v = 1'b1;
    val = '0;
    if (fwd && frd == rs) begin
      val = fres;
    end else if (rs == '0) begin
      val = '0;
    end else if (!renamed[rs]) begin
      val = arch[rs];
    end else if (!pend[rs]) begin
      val = spec[rs];
    end else begin
      v = 1'b0;
      val[`RENAME_ROB_ID_W-1:0] = tagr[rs];
    end
    return val;
  endfunction

  // advance the reference by the clock edge that just passed
  task automatic apply_edge();
    rename_pkg::rob_id_t wid;
    rename_pkg::arch_reg_t wrd;
    if (flushing) begin
      for (int i = 0; i < 32; i++) begin
        pend[i] = 1'b0;
        renamed[i] = 1'b0;
      end
      for (int j = 0; j < `RENAME_ROB_DEPTH; j++) begin
        ent_done[j] = 1'b0;
      end
      head_m = '0;
      tail_m = '0;
      count_m = 0;
      flushing = 1'b0;
    end else begin
      if (wb_valid) begin
        wid = wb_robid;
        wrd = ent_rd[wid];
        if (!wb_error && ent_has[wid] && wrd != '0 && tagr[wrd] == wid) begin
          spec[wrd] = wb_result;
          pend[wrd] = 1'b0;
        end
        ent_done[wid] = 1'b1;
        ent_err[wid] = wb_error;
        ent_res[wid] = wb_result;
      end
      if (rename_valid && exp_ready) begin
        ent_done[tail_m] = 1'b0;
        ent_has[tail_m] = rename_has_rd;
        ent_rd[tail_m] = rename_rd;
        if (rename_has_rd && rename_rd != '0) begin
          pend[rename_rd] = 1'b1;
          renamed[rename_rd] = 1'b1;
          tagr[rename_rd] = tail_m;
        end
        tail_m = tail_m + 1'b1;
        count_m++;
      end
      if (exp_retire) begin
        if (exp_ret_has && exp_ret_rd != '0) begin
          arch[exp_ret_rd] = exp_ret_res;
        end
        head_m = head_m + 1'b1;
        count_m--;
      end
      flushing = go_flush;
    end
  endtask

  task automatic predict();
    logic fwd_on;
    rename_pkg::arch_reg_t frd;
    logic head_ok;
    frd = ent_rd[wb_robid];
    fwd_on = wb_valid && !wb_error && ent_has[wb_robid] && frd != '0 && tagr[frd] == wb_robid;
    head_ok = !flushing && count_m > 0 && ent_done[head_m];
    exp_ready = (count_m != `RENAME_ROB_DEPTH) && !flushing;
    exp_robid = tail_m;
    exp_flush = flushing;
    exp_retire = head_ok && !ent_err[head_m];
    go_flush = head_ok && ent_err[head_m];
    exp_ret_rd = ent_rd[head_m];
    exp_ret_has = ent_has[head_m];
    exp_ret_res = ent_res[head_m];
    exp_rs1_val = src_expect(rename_rs1, fwd_on, frd, wb_result, exp_rs1_valid);
    exp_rs2_val = src_expect(rename_rs2, fwd_on, frd, wb_result, exp_rs2_valid);
  endtask

  // one cycle of stimulus
  task automatic drive(input logic v, input rename_pkg::arch_reg_t r1,
      input rename_pkg::arch_reg_t r2, input logic hr, input rename_pkg::arch_reg_t rd,
      input logic wv, input rename_pkg::rob_id_t wid, input rename_pkg::word_t wres,
      input logic werr);
    @(negedge clk);
    apply_edge();
    test_end = end_req;
    end_req = 1'b0;
    rename_valid = v;
    rename_rs1 = r1;
    rename_rs2 = r2;
    rename_has_rd = hr;
    rename_rd = rd;
    wb_valid = wv;
    wb_robid = wid;
    wb_result = wres;
    wb_error = werr;
    predict();
    chk_en = 1'b1;
    accepted = v && exp_ready;
    if (accepted) begin
      outstanding.push_back(exp_robid);
    end
  endtask

  function automatic rename_pkg::arch_reg_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return {2'b00, r[2:0]};
  endfunction

  task automatic idle(input rename_pkg::arch_reg_t r1, input rename_pkg::arch_reg_t r2);
    drive(1'b0, r1, r2, 1'b0, '0, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic rename_req(input rename_pkg::arch_reg_t r1, input rename_pkg::arch_reg_t r2,
      input logic hr, input rename_pkg::arch_reg_t rd);
    do begin
      drive(1'b1, r1, r2, hr, rd, 1'b0, '0, '0, 1'b0);
    end while (!accepted);
  endtask

  task automatic writeback(input rename_pkg::rob_id_t id, input rename_pkg::word_t res,
      input logic err, input rename_pkg::arch_reg_t r1, input rename_pkg::arch_reg_t r2);
    drive(1'b0, r1, r2, 1'b0, '0, 1'b1, id, res, err);
  endtask

  // writebacks for every outstanding id in random order
  task automatic random_writebacks();
    logic [31:0] r;
    int idx;
    rename_pkg::rob_id_t id;
    while (outstanding.size() > 0) begin
      r = $random(seed);
      idx = int'(r[7:0]) % outstanding.size();
      id = outstanding[idx];
      outstanding.delete(idx);
      writeback(id, $random(seed), 1'b0, rand_reg(), rand_reg());
    end
  endtask

  task automatic drain();
    while (count_m != 0 || flushing || go_flush) begin
      idle(rand_reg(), rand_reg());
    end
  endtask

  task automatic finish_test(input int n);
    test_num = n;
    end_req = 1'b1;
    idle('0, '0);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
      spec[i] = '0;
      pend[i] = 1'b0;
      renamed[i] = 1'b0;
      tagr[i] = '0;
    end
    for (int j = 0; j < `RENAME_ROB_DEPTH; j++) begin
      ent_done[j] = 1'b0;
      ent_err[j] = 1'b0;
      ent_has[j] = 1'b0;
      ent_rd[j] = '0;
      ent_res[j] = '0;
    end
    @(negedge reset);
    for (int r = 0; r < 32; r++) begin
      idle(5'(r), 5'(31 - r));
    end
    finish_test(1);
    // pending read, writeback forward, then speculative read
    rename_req('0, '0, 1'b1, 5'd5);
    idle(5'd5, 5'd1);
    writeback(outstanding.pop_front(), 32'h1234_5678, 1'b0, 5'd5, 5'd0);
    idle(5'd5, 5'd5);
    drain();
    finish_test(2);
    // some requests carry no destination
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < 6; k++) begin
        rename_req(rand_reg(), rand_reg(), k % 3 != 1, rand_reg());
      end
      random_writebacks();
    end
    drain();
    finish_test(3);
    // no writebacks, so the ROB fills and the next request waits on the inputs
    for (int k = 0; k < `RENAME_ROB_DEPTH; k++) begin
      rename_req(rand_reg(), rand_reg(), 1'b1, 5'(k % 4 + 1));
    end
    drive(1'b1, 5'd1, 5'd2, 1'b1, 5'd4, 1'b0, '0, '0, 1'b0);
    drive(1'b1, 5'd1, 5'd2, 1'b1, 5'd4, 1'b1, outstanding.pop_front(), $random(seed), 1'b0);
    rename_req(5'd1, 5'd2, 1'b1, 5'd4);
    while (outstanding.size() > 0) begin
      writeback(outstanding.pop_front(), $random(seed), 1'b0, rand_reg(), rand_reg());
    end
    drain();
    finish_test(4);
    rename_req(5'd3, 5'd4, 1'b1, 5'd3);
    rename_req(5'd3, 5'd4, 1'b1, 5'd4);
    rename_req(5'd3, 5'd4, 1'b1, 5'd3);
    writeback(outstanding[1], 32'hbeef_0004, 1'b0, 5'd4, 5'd3);
    writeback(outstanding[0], 32'hbad0_0003, 1'b1, 5'd3, 5'd4);
    outstanding.delete();
    drain();
    for (int r = 0; r < 32; r++) begin
      idle(5'(r), 5'(31 - r));
    end
    rename_req(5'd3, 5'd4, 1'b1, 5'd6);
    writeback(outstanding.pop_front(), 32'h0000_0066, 1'b0, 5'd6, 5'd3);
    drain();
    finish_test(5);
    rename_req('0, '0, 1'b1, '0);
    writeback(outstanding.pop_front(), 32'hdead_beef, 1'b0, 5'd0, 5'd0);
    drain();
    idle(5'd0, 5'd0);
    finish_test(6);
    @(negedge clk);
    chk_en = 1'b0;
    test_end = 1'b0;
    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    @(negedge clk);
    if (err_total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #((test_cycles + margin_cycles) * 40);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
// testbench clock of 40 ns period; reset held high for the first 16 rising edges
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* verilog/rename_top.sv */
// rename and retire top; one rename per cycle, writebacks have no back-pressure
`timescale 1ns/1ns

module rename_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rename_valid,
  output logic                  rename_ready,
  input  rename_pkg::arch_reg_t rename_rs1,
  input  rename_pkg::arch_reg_t rename_rs2,
  input  logic                  rename_has_rd,
  input  rename_pkg::arch_reg_t rename_rd,
  output rename_pkg::rob_id_t   rename_robid,
  output logic                  rs1_valid,
  output rename_pkg::word_t     rs1_tagval,
  output logic                  rs2_valid,
  output rename_pkg::word_t     rs2_tagval,
  input  logic                  wb_valid,
  input  rename_pkg::rob_id_t   wb_robid,
  input  rename_pkg::word_t     wb_result,
  input  logic                  wb_error,
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_rd,
  output logic                  retire_has_rd,
  output rename_pkg::word_t     retire_result,
  output logic                  flush
);

  rename_pkg::rob_id_t   head;
  rename_pkg::rob_id_t   tail;
  logic                  full;
  logic                  empty;
  logic                  alloc;
  logic                  commit;
  logic                  rob_flush;
  logic                  head_done;
  logic                  head_error;
  logic                  head_has_rd;
  rename_pkg::arch_reg_t head_rd;
  rename_pkg::word_t     head_result;
  logic                  wb_has_rd;
  rename_pkg::arch_reg_t wb_rd;

  // every accepted request takes an entry, even without a destination
  assign rename_ready = !full && !rob_flush;
  assign alloc = rename_valid && rename_ready;
  assign rename_robid = tail;

  assign retire_valid = commit;
  assign retire_rd = head_rd;
  assign retire_has_rd = head_has_rd;
  assign retire_result = head_result;
  assign flush = rob_flush;

  rob_ptr_counter u_ptr (
    .clk(clk), .reset(reset), .alloc(alloc), .commit(commit), .rob_flush(rob_flush),
    .head(head), .tail(tail), .full(full), .empty(empty)
  );

  rob_store u_store (
    .clk(clk), .reset(reset), .alloc(alloc), .tail(tail),
    .rename_has_rd(rename_has_rd), .rename_rd(rename_rd),
    .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_result(wb_result), .wb_error(wb_error),
    .head(head), .rob_flush(rob_flush),
    .head_done(head_done), .head_error(head_error), .head_has_rd(head_has_rd),
    .head_rd(head_rd), .head_result(head_result), .wb_has_rd(wb_has_rd), .wb_rd(wb_rd)
  );

  retire_fsm u_retire (
    .clk(clk), .reset(reset), .empty(empty), .head_done(head_done),
    .head_error(head_error), .commit(commit), .rob_flush(rob_flush)
  );

  // tag recorded only when the request writes a register
  rat u_rat (
    .clk(clk), .reset(reset),
    .rename_rs1(rename_rs1), .rename_rs2(rename_rs2),
    .rename_alloc(alloc && rename_has_rd), .rename_rd(rename_rd), .rename_robid(tail),
    .wb_valid(wb_valid), .wb_error(wb_error), .wb_robid(wb_robid),
    .wb_has_rd(wb_has_rd), .wb_rd(wb_rd), .wb_result(wb_result),
    .rob_flush(rob_flush), .commit(commit),
    .head_has_rd(head_has_rd), .head_rd(head_rd), .head_result(head_result),
    .rs1_valid(rs1_valid), .rs1_tagval(rs1_tagval),
    .rs2_valid(rs2_valid), .rs2_tagval(rs2_tagval)
  );

endmodule

/* verilog/retire_fsm.sv */
// in-order retire; an errored head costs one flush cycle and never commits
`timescale 1ns/1ns

module retire_fsm (
  input  logic clk,
  input  logic reset,
  input  logic empty,
  input  logic head_done,
  input  logic head_error,
  output logic commit,
  output logic rob_flush
);

  rename_pkg::retire_state_t state;
  rename_pkg::retire_state_t state_next;

  logic head_ready;

  assign head_ready = !empty && head_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rename_pkg::ret_run;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    commit = 1'b0;
    rob_flush = 1'b0;
    case (state)
      rename_pkg::ret_run: begin
        if (head_ready && head_error) begin
          state_next = rename_pkg::ret_flush;
        end
        commit = head_ready && !head_error;
      end
      rename_pkg::ret_flush: begin
        // single cycle, then back to normal retire
        rob_flush = 1'b1;
        state_next = rename_pkg::ret_run;
      end
      default: state_next = rename_pkg::ret_run;
    endcase
  end

endmodule
